//--- ff_bus_pkg.sv
// ************************************************
// APB side definitions: byte address map of the
// playfield, pattern and colour RAMs, the region
// decode result and the control register bits
// ************************************************

`default_nettype none

package ff_bus_pkg;

   typedef logic [12:0] apb_addr_t;
   typedef logic [15:0] apb_data_t;

   // region bases, byte addresses with word stride
   localparam apb_addr_t PF_BASE   = 13'h0000;
   localparam apb_addr_t PAT_BASE  = 13'h0800;
   localparam apb_addr_t COL_BASE  = 13'h1000;
   localparam apb_addr_t CTRL_ADDR = 13'h1800;

   typedef enum logic [2:0]
   {
      REG_PF,
      REG_PAT,
      REG_COL,
      REG_CTRL,
      REG_NONE
   } region_e;

   // control register bit positions
   localparam int CTRL_PFFLIP = 0;
   localparam int CTRL_LED1   = 4;
   localparam int CTRL_LED2   = 5;

endpackage

`default_nettype wire

//--- ff_video_pkg.sv
// ************************************************
// video side definitions: default screen timing,
// tile and map geometry, pipeline latency and the
// playfield word with its field view
// ************************************************

`default_nettype none

package ff_video_pkg;

   import ff_bus_pkg::*;

   // default timing, the top level passes these down
   localparam int DEF_H_ACTIVE    = 256;
   localparam int DEF_H_TOTAL     = 384;
   localparam int DEF_V_ACTIVE    = 232;
   localparam int DEF_V_TOTAL     = 256;
   localparam int DEF_HSYNC_START = 288;
   localparam int DEF_HSYNC_LEN   = 32;
   localparam int DEF_VSYNC_START = 240;
   localparam int DEF_VSYNC_LEN   = 4;

   // tile geometry
   localparam int TILE_PX  = 8;
   localparam int MAP_COLS = 32;

   // cycles from pixel position to rgb output
   localparam int PIPE_LAT = 5;

   typedef logic [8:0] pix_x_t;
   typedef logic [7:0] pix_y_t;

   // one tile row, pixel 0 in bits 15:14
   typedef logic [15:0] pat_row_t;

   typedef logic [7:0] rgb_t;

   typedef struct packed
   {
      logic       bank;
      logic       spare;
      logic [5:0] palette;
      logic [7:0] tile;
   } pf_fields_t;

   // same word as the cpu writes it and as the tile fetch reads it
   typedef union packed
   {
      apb_data_t  raw;
      pf_fields_t f;
   } pf_word_u;

endpackage

`default_nettype wire

//--- ff_sync_gen.sv
// ************************************************
// video timing: pixel and line counters with the
// active, hsync and vsync flags for the position
// currently on o_x / o_y
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module ff_sync_gen
   import ff_video_pkg::*;
#(
   parameter int H_ACTIVE    = DEF_H_ACTIVE,
   parameter int H_TOTAL     = DEF_H_TOTAL,
   parameter int V_ACTIVE    = DEF_V_ACTIVE,
   parameter int V_TOTAL     = DEF_V_TOTAL,
   parameter int HSYNC_START = DEF_HSYNC_START,
   parameter int HSYNC_LEN   = DEF_HSYNC_LEN,
   parameter int VSYNC_START = DEF_VSYNC_START,
   parameter int VSYNC_LEN   = DEF_VSYNC_LEN
)
(
   input  wire    s_6mhz,
   input  wire    blank_n,
   output pix_x_t o_x,
   output pix_y_t o_y,
   output logic   o_active,
   output logic   o_hsync,
   output logic   o_vsync
);

   pix_x_t x_nxt;
   pix_y_t y_nxt;
   logic   line_end;

   assign line_end = (o_x == pix_x_t'(H_TOTAL - 1));

   // next position, vertical steps at the end of each line
   always_comb
   begin
      if (line_end)
      begin
         x_nxt = '0;
         if (o_y == pix_y_t'(V_TOTAL - 1))
            y_nxt = '0;
         else
            y_nxt = o_y + 8'd1;
      end
      else
      begin
         x_nxt = o_x + 9'd1;
         y_nxt = o_y;
      end
   end

   // flags compared on the next position so they line up with the counters
   always_ff @(posedge s_6mhz or negedge blank_n)
   begin
      if (!blank_n)
      begin
         o_x      <= '0;
         o_y      <= '0;
         // (0,0) is always inside the visible area
         o_active <= 1'b1;
         o_hsync  <= 1'b0;
         o_vsync  <= 1'b0;
      end
      else
      begin
         o_x      <= x_nxt;
         o_y      <= y_nxt;
         o_active <= (x_nxt < H_ACTIVE) && (y_nxt < V_ACTIVE);
         o_hsync  <= (x_nxt >= HSYNC_START) && (x_nxt < HSYNC_START + HSYNC_LEN);
         o_vsync  <= (y_nxt >= VSYNC_START) && (y_nxt < VSYNC_START + VSYNC_LEN);
      end
   end

endmodule

`default_nettype wire

//--- ff_apb_regs.sv
// ************************************************
// APB slave: decodes the byte address into a RAM
// region or the control register, issues write
// strobes and runs the playfield read wait state
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module ff_apb_regs
   import ff_bus_pkg::*;
(
   input  wire         s_6mhz,
   input  wire         blank_n,
   input  wire         i_psel,
   input  wire         i_penable,
   input  wire         i_pwrite,
   input  wire apb_addr_t i_paddr,
   input  wire apb_data_t i_pwdata,
   input  wire apb_data_t i_pf_rdata,
   output apb_data_t   o_prdata,
   output logic        o_pready,
   output logic        o_pslverr,
   output logic        o_pf_we,
   output logic        o_pat_we,
   output logic        o_col_we,
   output logic [10:0] o_wr_index,
   output apb_data_t   o_wr_data,
   output logic [9:0]  o_pf_rd_index,
   output logic        o_pfflip,
   output logic        o_led1,
   output logic        o_led2
);

   region_e   region;
   logic      access;
   logic      wr;
   logic      pf_read;
   logic      rd_wait;
   apb_data_t ctrl_rd;

   // region decode on the upper address bits
   always_comb
   begin
      if (i_paddr[12:11] == PF_BASE[12:11])
         region = REG_PF;
      else if (i_paddr[12:10] == PAT_BASE[12:10])
         region = REG_PAT;
      else if (i_paddr[12:9] == COL_BASE[12:9])
         region = REG_COL;
      else if (i_paddr[12:1] == CTRL_ADDR[12:1])
         region = REG_CTRL;
      else
         region = REG_NONE;
   end

   assign access  = i_psel & i_penable;
   assign wr      = access & i_pwrite;
   assign pf_read = access & ~i_pwrite & (region == REG_PF);

   // playfield reads finish in the second access cycle
   always_ff @(posedge s_6mhz or negedge blank_n)
   begin
      if (!blank_n)
         rd_wait <= 1'b0;
      else
         rd_wait <= pf_read & ~rd_wait;
   end

   assign o_pready  = access & (~pf_read | rd_wait);
   assign o_pslverr = access & (region == REG_NONE);

   assign o_pf_we  = wr & (region == REG_PF);
   assign o_pat_we = wr & (region == REG_PAT);
   assign o_col_we = wr & (region == REG_COL);

   // region relative word index
   always_comb
   begin
      case (region)
         REG_PF:  o_wr_index = {1'b0, i_paddr[10:1]};
         REG_PAT: o_wr_index = {2'b0, i_paddr[9:1]};
         REG_COL: o_wr_index = {3'b0, i_paddr[8:1]};
         default: o_wr_index = '0;
      endcase
   end

   assign o_wr_data = i_pwdata;

   // index latched in setup, RAM reads it during the first access cycle
   always_ff @(posedge s_6mhz)
   begin
      if (i_psel && !i_penable)
         o_pf_rd_index <= i_paddr[10:1];
   end

   always_ff @(posedge s_6mhz or negedge blank_n)
   begin
      if (!blank_n)
      begin
         o_pfflip <= 1'b0;
         o_led1   <= 1'b0;
         o_led2   <= 1'b0;
      end
      else if (wr && region == REG_CTRL)
      begin
         o_pfflip <= i_pwdata[CTRL_PFFLIP];
         o_led1   <= i_pwdata[CTRL_LED1];
         o_led2   <= i_pwdata[CTRL_LED2];
      end
   end

   always_comb
   begin
      ctrl_rd              = '0;
      ctrl_rd[CTRL_PFFLIP] = o_pfflip;
      ctrl_rd[CTRL_LED1]   = o_led1;
      ctrl_rd[CTRL_LED2]   = o_led2;
   end

   // pattern and colour are write only and read as zero
   always_comb
   begin
      case (region)
         REG_CTRL: o_prdata = ctrl_rd;
         REG_PF:   o_prdata = i_pf_rdata;
         default:  o_prdata = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- ff_playfield.sv
// ************************************************
// playfield: tile map and tile graphics RAMs, both
// also written from the APB side; three stages turn
// a pixel position into a palette / pixel index
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module ff_playfield
   import ff_video_pkg::*;
#(
   parameter int H_ACTIVE = DEF_H_ACTIVE
)
(
   input  wire         s_6mhz,
   input  wire         blank_n,
   input  wire pix_x_t i_x,
   input  wire pix_y_t i_y,
   input  wire         i_active,
   input  wire         i_hsync,
   input  wire         i_vsync,
   input  wire         i_pfflip,
   input  wire         i_pf_we,
   input  wire         i_pat_we,
   input  wire [10:0]  i_wr_index,
   input  wire [15:0]  i_wr_data,
   input  wire [9:0]   i_pf_rd_index,
   output logic [15:0] o_pf_rdata,
   output logic [7:0]  o_pix_index,
   output logic        o_active,
   output logic        o_hsync,
   output logic        o_vsync
);

   localparam int TILE_BITS = $clog2(TILE_PX);
   localparam int COL_BITS  = $clog2(MAP_COLS);

   logic [15:0] pf_ram [1024];
   pat_row_t    pat_ram [512];

   logic [9:0]  vid_addr;
   logic        vid_rd_en;

   // stage 1
   pf_word_u    pf_q;
   logic [2:0]  ofs_x_q;
   logic [2:0]  ofs_y_q;

   // stage 2
   pat_row_t    pat_q;
   logic [5:0]  pal_q;
   logic [2:0]  ofs_x_q2;

   // timing flags, one bit per stage
   logic [2:0]  act_d;
   logic [2:0]  hs_d;
   logic [2:0]  vs_d;

   // cpu port of the playfield RAM
   always_ff @(posedge s_6mhz)
   begin
      if (i_pf_we)
         pf_ram[i_wr_index[9:0]] <= i_wr_data;
      o_pf_rdata <= pf_ram[i_pf_rd_index];
   end

   always_ff @(posedge s_6mhz)
   begin
      if (i_pat_we)
         pat_ram[i_wr_index[8:0]] <= i_wr_data;
   end

   // row y/8, column x/8
   assign vid_addr  = {i_y[TILE_BITS +: COL_BITS], i_x[TILE_BITS +: COL_BITS]};
   // no tile fetch past the visible width
   assign vid_rd_en = (i_x < H_ACTIVE);

   // stage 1: map read, in-tile offsets mirrored when flipped
   always_ff @(posedge s_6mhz)
   begin
      if (vid_rd_en)
         pf_q.raw <= pf_ram[vid_addr];
      ofs_x_q <= i_x[TILE_BITS-1:0] ^ {3{i_pfflip}};
      ofs_y_q <= i_y[TILE_BITS-1:0] ^ {3{i_pfflip}};
   end

   // stage 2: tile row fetch, 64 tiles of 8 rows
   always_ff @(posedge s_6mhz)
   begin
      pat_q    <= pat_ram[{pf_q.f.bank, pf_q.f.tile[4:0], ofs_y_q}];
      pal_q    <= pf_q.f.palette;
      ofs_x_q2 <= ofs_x_q;
   end

   // stage 3: pick the 2 bit pixel, pixel 0 sits in the top bits
   always_ff @(posedge s_6mhz)
   begin
      o_pix_index <= {pal_q, pat_q[{~ofs_x_q2, 1'b0} +: 2]};
   end

   always_ff @(posedge s_6mhz or negedge blank_n)
   begin
      if (!blank_n)
      begin
         act_d <= '0;
         hs_d  <= '0;
         vs_d  <= '0;
      end
      else
      begin
         act_d <= {act_d[1:0], i_active};
         hs_d  <= {hs_d[1:0], i_hsync};
         vs_d  <= {vs_d[1:0], i_vsync};
      end
   end

   assign o_active = act_d[2];
   assign o_hsync  = hs_d[2];
   assign o_vsync  = vs_d[2];

endmodule

`default_nettype wire

//--- ff_color_out.sv
// ************************************************
// colour lookup and output register: palette index
// to 8 bit rgb, black outside the active area, with
// blank and syncs registered alongside
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module ff_color_out
   import ff_video_pkg::*;
(
   input  wire        s_6mhz,
   input  wire        blank_n,
   input  wire [7:0]  i_pix_index,
   input  wire        i_active,
   input  wire        i_hsync,
   input  wire        i_vsync,
   input  wire        i_col_we,
   input  wire [10:0] i_wr_index,
   input  wire [15:0] i_wr_data,
   output rgb_t       o_rgb,
   output logic       o_blank,
   output logic       o_hsync,
   output logic       o_vsync
);

   rgb_t col_ram [256];
   rgb_t col_q;
   logic act_q;
   logic hs_q;
   logic vs_q;

   // cpu writes only the low byte
   always_ff @(posedge s_6mhz)
   begin
      if (i_col_we)
         col_ram[i_wr_index[7:0]] <= i_wr_data[7:0];
   end

   always_ff @(posedge s_6mhz)
   begin
      col_q <= col_ram[i_pix_index];
   end

   always_ff @(posedge s_6mhz or negedge blank_n)
   begin
      if (!blank_n)
      begin
         act_q <= 1'b0;
         hs_q  <= 1'b0;
         vs_q  <= 1'b0;
      end
      else
      begin
         act_q <= i_active;
         hs_q  <= i_hsync;
         vs_q  <= i_vsync;
      end
   end

   // output register, blank stays high until real pixels arrive
   always_ff @(posedge s_6mhz or negedge blank_n)
   begin
      if (!blank_n)
      begin
         o_rgb   <= '0;
         o_blank <= 1'b1;
         o_hsync <= 1'b0;
         o_vsync <= 1'b0;
      end
      else
      begin
         o_rgb   <= act_q ? col_q : '0;
         o_blank <= ~act_q;
         o_hsync <= hs_q;
         o_vsync <= vs_q;
      end
   end

endmodule

`default_nettype wire

//--- ff_video_top.sv
// ************************************************
// video top: sync, playfield and colour stages in
// a row, with the APB slave beside them for RAM and
// control register access
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module ff_video_top
   import ff_bus_pkg::*;
   import ff_video_pkg::*;
#(
   parameter int H_ACTIVE    = DEF_H_ACTIVE,
   parameter int H_TOTAL     = DEF_H_TOTAL,
   parameter int V_ACTIVE    = DEF_V_ACTIVE,
   parameter int V_TOTAL     = DEF_V_TOTAL,
   parameter int HSYNC_START = DEF_HSYNC_START,
   parameter int HSYNC_LEN   = DEF_HSYNC_LEN,
   parameter int VSYNC_START = DEF_VSYNC_START,
   parameter int VSYNC_LEN   = DEF_VSYNC_LEN
)
(
   input  wire            s_6mhz,
   input  wire            blank_n,
   input  wire            i_psel,
   input  wire            i_penable,
   input  wire            i_pwrite,
   input  wire apb_addr_t i_paddr,
   input  wire apb_data_t i_pwdata,
   output apb_data_t      o_prdata,
   output logic           o_pready,
   output logic           o_pslverr,
   output rgb_t           o_rgb,
   output logic           o_hsync,
   output logic           o_vsync,
   output logic           o_blank,
   output logic           o_led1,
   output logic           o_led2
);

   // sync stage outputs
   pix_x_t      x;
   pix_y_t      y;
   logic        sg_active;
   logic        sg_hsync;
   logic        sg_vsync;

   // playfield stage outputs
   logic [7:0]  pix_index;
   logic        pf_active;
   logic        pf_hsync;
   logic        pf_vsync;

   // cpu side
   logic        pf_we;
   logic        pat_we;
   logic        col_we;
   logic [10:0] wr_index;
   apb_data_t   wr_data;
   logic [9:0]  pf_rd_index;
   apb_data_t   pf_rdata;
   logic        pfflip;

   ff_sync_gen #(
      .H_ACTIVE    (H_ACTIVE),
      .H_TOTAL     (H_TOTAL),
      .V_ACTIVE    (V_ACTIVE),
      .V_TOTAL     (V_TOTAL),
      .HSYNC_START (HSYNC_START),
      .HSYNC_LEN   (HSYNC_LEN),
      .VSYNC_START (VSYNC_START),
      .VSYNC_LEN   (VSYNC_LEN)
   ) i_sync (
      .s_6mhz   (s_6mhz),
      .blank_n  (blank_n),
      .o_x      (x),
      .o_y      (y),
      .o_active (sg_active),
      .o_hsync  (sg_hsync),
      .o_vsync  (sg_vsync)
   );

   ff_apb_regs i_regs (
      .s_6mhz        (s_6mhz),
      .blank_n       (blank_n),
      .i_psel        (i_psel),
      .i_penable     (i_penable),
      .i_pwrite      (i_pwrite),
      .i_paddr       (i_paddr),
      .i_pwdata      (i_pwdata),
      .i_pf_rdata    (pf_rdata),
      .o_prdata      (o_prdata),
      .o_pready      (o_pready),
      .o_pslverr     (o_pslverr),
      .o_pf_we       (pf_we),
      .o_pat_we      (pat_we),
      .o_col_we      (col_we),
      .o_wr_index    (wr_index),
      .o_wr_data     (wr_data),
      .o_pf_rd_index (pf_rd_index),
      .o_pfflip      (pfflip),
      .o_led1        (o_led1),
      .o_led2        (o_led2)
   );

   ff_playfield #(
      .H_ACTIVE (H_ACTIVE)
   ) i_playfield (
      .s_6mhz        (s_6mhz),
      .blank_n       (blank_n),
      .i_x           (x),
      .i_y           (y),
      .i_active      (sg_active),
      .i_hsync       (sg_hsync),
      .i_vsync       (sg_vsync),
      .i_pfflip      (pfflip),
      .i_pf_we       (pf_we),
      .i_pat_we      (pat_we),
      .i_wr_index    (wr_index),
      .i_wr_data     (wr_data),
      .i_pf_rd_index (pf_rd_index),
      .o_pf_rdata    (pf_rdata),
      .o_pix_index   (pix_index),
      .o_active      (pf_active),
      .o_hsync       (pf_hsync),
      .o_vsync       (pf_vsync)
   );

   ff_color_out i_color (
      .s_6mhz      (s_6mhz),
      .blank_n     (blank_n),
      .i_pix_index (pix_index),
      .i_active    (pf_active),
      .i_hsync     (pf_hsync),
      .i_vsync     (pf_vsync),
      .i_col_we    (col_we),
      .i_wr_index  (wr_index),
      .i_wr_data   (wr_data),
      .o_rgb       (o_rgb),
      .o_blank     (o_blank),
      .o_hsync     (o_hsync),
      .o_vsync     (o_vsync)
   );

endmodule

`default_nettype wire

//--- tb_ff_video.sv
// ************************************************
// testbench for the video top: APB access tasks,
// shadow copies of the RAMs, a reference pixel
// model and a frame compare running on o_blank
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_ff_video
   import ff_bus_pkg::*;
   import ff_video_pkg::*;
;

   localparam int H_ACT     = 64;
   localparam int H_TOT     = 96;
   localparam int V_ACT     = 32;
   localparam int V_TOT     = 40;
   localparam int HS_START  = 72;
   localparam int HS_LEN    = 8;
   localparam int VS_START  = 34;
   localparam int VS_LEN    = 2;
   localparam int FRAME_CYC = H_TOT * V_TOT;
   localparam int CYC_LIMIT = 4 * FRAME_CYC + 20000;
   localparam apb_data_t CTRL_MASK = apb_data_t'((1 << CTRL_PFFLIP) | (1 << CTRL_LED1)
                                                 | (1 << CTRL_LED2));

   logic      s_6mhz;
   logic      blank_n;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      pready;
   logic      pslverr;
   rgb_t      rgb;
   logic      hsync;
   logic      vsync;
   logic      blank;
   logic      led1;
   logic      led2;

   // shadow copies of what the cpu side wrote
   apb_data_t pf_sh [1024];
   pat_row_t  pat_sh [512];
   rgb_t      col_sh [256];
   apb_data_t ctrl_sh;
   int        pf_idx [32];

   logic [31:0] lfsr_state;
   int          check_cnt;
   int          err_cnt;
   int          err_mark;
   int          cyc;

   // frame compare state
   int   px;
   int   py;
   int   lx;
   int   ly;
   int   frame_cnt;
   int   pix_cnt;
   logic prev_blank;
   logic prev_vs;
   logic checking;
   logic arm;
   logic exp_flip;

   ff_video_top #(
      .H_ACTIVE    (H_ACT),
      .H_TOTAL     (H_TOT),
      .V_ACTIVE    (V_ACT),
      .V_TOTAL     (V_TOT),
      .HSYNC_START (HS_START),
      .HSYNC_LEN   (HS_LEN),
      .VSYNC_START (VS_START),
      .VSYNC_LEN   (VS_LEN)
   ) i_dut (
      .s_6mhz    (s_6mhz),
      .blank_n   (blank_n),
      .i_psel    (psel),
      .i_penable (penable),
      .i_pwrite  (pwrite),
      .i_paddr   (paddr),
      .i_pwdata  (pwdata),
      .o_prdata  (prdata),
      .o_pready  (pready),
      .o_pslverr (pslverr),
      .o_rgb     (rgb),
      .o_hsync   (hsync),
      .o_vsync   (vsync),
      .o_blank   (blank),
      .o_led1    (led1),
      .o_led2    (led2)
   );

   initial
   begin
      s_6mhz = 1'b0;
      forever #4 s_6mhz = ~s_6mhz;
   end

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      int i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   // expected colour of one screen pixel from the shadow RAMs
   function automatic rgb_t expected_rgb(input int x, input int y, input logic flip);
      apb_data_t  word;
      pat_row_t   row;
      int         ox;
      int         oy;
      logic [1:0] pix;
      word = pf_sh[(y / TILE_PX) * MAP_COLS + (x / TILE_PX)];
      ox = flip ? 7 - (x % TILE_PX) : x % TILE_PX;
      oy = flip ? 7 - (y % TILE_PX) : y % TILE_PX;
      // bank bit 15, tile code bits 4:0, then the row in the tile
      row = pat_sh[int'(word[15]) * 256 + int'(word[4:0]) * 8 + oy];
      pix = row[15 - 2 * ox -: 2];
      return col_sh[{word[13:8], pix}];
   endfunction

   task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
      check_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("[ERROR] %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
      check_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("[ERROR] %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      check_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("[ERROR] %0t ns: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string msg);
      err_cnt++;
      $display("error at %0t ns: %s", $time, msg);
   endtask

   task automatic test_done(input string name);
      $display("%s finished with %0d errors", name, err_cnt - err_mark);
      err_mark = err_cnt;
   endtask

   // one APB transfer, setup and access on falling edges, idle afterwards
   task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                             output apb_data_t rdata, output logic err, output int waits);
      int n;
      n = 0;
      @(negedge s_6mhz);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge s_6mhz);
      penable = 1'b1;
      @(posedge s_6mhz);
      while (!pready && n < 8)
      begin
         n++;
         @(posedge s_6mhz);
      end
      if (!pready)
         report_failure($sformatf("no o_pready for the access at %h", addr));
      rdata = prdata;
      err   = pslverr;
      waits = n;
      @(negedge s_6mhz);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic write_word(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
      apb_data_t rd;
      logic      err;
      int        waits;
      apb_access(1'b1, addr, data, rd, err, waits);
      check_bit("o_pslverr", err, exp_err);
      if (waits != 0)
         report_failure($sformatf("write at %h took %0d wait states", addr, waits));
   endtask

   task automatic read_word(input apb_addr_t addr, input apb_data_t exp, input int exp_waits);
      apb_data_t rd;
      logic      err;
      int        waits;
      apb_access(1'b0, addr, '0, rd, err, waits);
      check_data("o_prdata", rd, exp);
      check_bit("o_pslverr", err, 1'b0);
      if (waits != exp_waits)
         report_failure($sformatf("read at %h took %0d wait states, expected %0d",
                                  addr, waits, exp_waits));
   endtask

   // arm the compare and wait until one whole frame has been checked
   task automatic check_frame(input logic flip);
      int start;
      int n;
      exp_flip = flip;
      start    = frame_cnt;
      n        = 0;
      arm      = 1'b1;
      while (frame_cnt == start && n < 3 * FRAME_CYC)
      begin
         n++;
         @(negedge s_6mhz);
      end
      if (frame_cnt == start)
         report_failure("no complete frame seen on the video output");
   endtask

   // frame compare, position tracked from the o_blank runs and vsync
   always @(posedge s_6mhz)
   begin
      if (!blank_n)
      begin
         px         = 0;
         py         = 0;
         lx         = 0;
         ly         = 0;
         prev_blank = 1'b1;
         prev_vs    = 1'b0;
         checking   = 1'b0;
      end
      else
      begin
         if (vsync && !prev_vs)
         begin
            if (checking)
            begin
               if (py != V_ACT)
                  report_failure($sformatf("frame had %0d active lines", py));
               frame_cnt++;
               checking = 1'b0;
            end
            if (arm)
            begin
               checking = 1'b1;
               arm      = 1'b0;
            end
            py = 0;
         end
         // line and column of the sample, restarted at the first active pixel
         if (!blank && prev_blank && py == 0)
         begin
            lx = 0;
            ly = 0;
         end
         else if (lx == H_TOT - 1)
         begin
            lx = 0;
            ly++;
         end
         else
            lx++;
         if (checking)
         begin
            check_bit("o_hsync", hsync, lx >= HS_START && lx < HS_START + HS_LEN);
            check_bit("o_vsync", vsync, ly >= VS_START && ly < VS_START + VS_LEN);
         end
         if (!blank)
         begin
            if (checking)
            begin
               check_rgb("o_rgb", rgb, expected_rgb(px, py, exp_flip));
               pix_cnt++;
            end
            px++;
         end
         else
         begin
            check_rgb("o_rgb during blank", rgb, '0);
            if (!prev_blank)
            begin
               if (checking && px != H_ACT)
                  report_failure($sformatf("line %0d had %0d active pixels", py, px));
               py++;
               px = 0;
            end
         end
         prev_blank = blank;
         prev_vs    = vsync;
      end
   end

   // run limit
   always @(posedge s_6mhz)
   begin
      cyc++;
      if (cyc >= CYC_LIMIT)
      begin
         $display("run stopped by timeout after %0d cycles", cyc);
         $display("TEST FAIL");
         $finish;
      end
   end

   initial
   begin
      logic [31:0] r;
      apb_data_t   ctrl_vals [4];
      int          i;
      blank_n    = 1'b0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      lfsr_state = 32'h595077ec;
      check_cnt  = 0;
      err_cnt    = 0;
      err_mark   = 0;
      cyc        = 0;
      frame_cnt  = 0;
      pix_cnt    = 0;
      arm        = 1'b0;
      exp_flip   = 1'b0;
      ctrl_sh    = '0;
      ctrl_vals  = '{16'h0030, 16'h0010, 16'hffef, 16'h0000};

      repeat (8) @(posedge s_6mhz);
      @(negedge s_6mhz);
      blank_n = 1'b1;
      @(negedge s_6mhz);
      check_bit("o_led1", led1, 1'b0);
      check_bit("o_led2", led2, 1'b0);
      check_bit("o_pready", pready, 1'b0);
      check_bit("o_pslverr", pslverr, 1'b0);
      check_rgb("o_rgb", rgb, '0);
      check_bit("o_blank", blank, 1'b1);
      check_bit("o_hsync", hsync, 1'b0);
      check_bit("o_vsync", vsync, 1'b0);
      test_done("reset state");

      for (i = 0; i < 4; i++)
      begin
         write_word(CTRL_ADDR, ctrl_vals[i], 1'b0);
         ctrl_sh = ctrl_vals[i] & CTRL_MASK;
         @(negedge s_6mhz);
         check_bit("o_led1", led1, ctrl_vals[i][CTRL_LED1]);
         check_bit("o_led2", led2, ctrl_vals[i][CTRL_LED2]);
         read_word(CTRL_ADDR, ctrl_sh, 0);
      end
      test_done("control register");

      for (i = 0; i < 32; i++)
      begin
         rand_bits(10, r);
         pf_idx[i] = int'(r[9:0]);
         rand_bits(16, r);
         pf_sh[pf_idx[i]] = r[15:0];
         write_word(PF_BASE + apb_addr_t'(pf_idx[i] * 2), r[15:0], 1'b0);
      end
      for (i = 0; i < 32; i++)
         read_word(PF_BASE + apb_addr_t'(pf_idx[i] * 2), pf_sh[pf_idx[i]], 1);
      test_done("playfield RAM");

      // holes in the map between and after the regions
      write_word(13'h0c00, 16'hffff, 1'b1);
      write_word(13'h1200, 16'h5a5a, 1'b1);
      write_word(13'h1804, 16'h0031, 1'b1);
      apb_access(1'b0, 13'h1ffe, '0, r[15:0], r[16], i);
      check_bit("o_pslverr", r[16], 1'b1);
      if (i != 0)
         report_failure($sformatf("unmapped read took %0d wait states", i));
      read_word(CTRL_ADDR, ctrl_sh, 0);
      for (i = 0; i < 4; i++)
         read_word(PF_BASE + apb_addr_t'(pf_idx[i] * 2), pf_sh[pf_idx[i]], 1);
      read_word(PAT_BASE, '0, 0);
      read_word(COL_BASE, '0, 0);
      test_done("unmapped address");

      for (i = 0; i < 1024; i++)
      begin
         rand_bits(16, r);
         pf_sh[i] = r[15:0];
         write_word(PF_BASE + apb_addr_t'(i * 2), r[15:0], 1'b0);
      end
      for (i = 0; i < 512; i++)
      begin
         rand_bits(16, r);
         pat_sh[i] = r[15:0];
         write_word(PAT_BASE + apb_addr_t'(i * 2), r[15:0], 1'b0);
      end
      for (i = 0; i < 256; i++)
      begin
         rand_bits(8, r);
         col_sh[i] = r[7:0];
         write_word(COL_BASE + apb_addr_t'(i * 2), {8'h00, r[7:0]}, 1'b0);
      end
      check_frame(1'b0);
      test_done("full frame");

      write_word(CTRL_ADDR, 16'h0001, 1'b0);
      ctrl_sh = 16'h0001;
      check_frame(1'b1);
      test_done("flip");

      $display("checks %0d, errors %0d, pixels compared %0d, frames %0d",
               check_cnt, err_cnt, pix_cnt, frame_cnt);
      if (err_cnt == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- ff_video_top.f
ff_bus_pkg.sv
ff_video_pkg.sv
ff_sync_gen.sv
ff_apb_regs.sv
ff_playfield.sv
ff_color_out.sv
ff_video_top.sv
tb_ff_video.sv

//--- Bender.yml
package:
  name: ff_video

sources:
  - files:
      - ff_bus_pkg.sv
      - ff_video_pkg.sv
      - ff_sync_gen.sv
      - ff_apb_regs.sv
      - ff_playfield.sv
      - ff_color_out.sv
      - ff_video_top.sv
  - target: test
    files:
      - tb_ff_video.sv
